/* Makefile */
# Verilator build and run of the TileLink-UH to SRAM adapter testbench

VERILATOR ?= verilator
TOP       ?= tb_tl_sram_adapter
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -j $(JOBS)

SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR JOBS VFLAGS"

$(SIM_BIN): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

# Pass only if the run prints the pass message
test: $(SIM_BIN)
	@out="$$(./$(SIM_BIN) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TEST RESULT: PASS"

clean:
	rm -rf $(OBJ_DIR)

/* build.f */
hdl/tl_sram_pkg.sv
hdl/tl_sram_fifo.sv
hdl/tl_req_check.sv
hdl/tl_atomic_alu.sv
hdl/tl_sram_ctrl.sv
hdl/tl_sram_adapter.sv
verification/sram_model.sv
verification/tb_tl_sram_adapter.sv

/* hdl/tl_atomic_alu.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Atomic ALU
// New memory word for ArithmeticData and LogicalData, merged with
// the old word outside the byte mask
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module tl_atomic_alu (
  input  logic                          arith_i,
  input  logic [2:0]                    param_i,
  input  logic [tl_sram_pkg::TlDbw-1:0] mask_i,
  input  logic [tl_sram_pkg::TlDw-1:0]  old_i,
  input  logic [tl_sram_pkg::TlDw-1:0]  operand_i,
  output logic [tl_sram_pkg::TlDw-1:0]  result_o
);

  logic [tl_sram_pkg::TlDw-1:0] raw;
  logic                         lt_s;
  logic                         lt_u;

  // Shared comparators for min and max
  assign lt_s = ($signed(old_i) < $signed(operand_i));
  assign lt_u = (old_i < operand_i);

  always_comb begin
    raw = old_i;
    if (arith_i) begin
      case (tl_sram_pkg::arith_param_e'(param_i))
        tl_sram_pkg::Min:  raw = lt_s ? old_i : operand_i;
        tl_sram_pkg::Max:  raw = lt_s ? operand_i : old_i;
        tl_sram_pkg::MinU: raw = lt_u ? old_i : operand_i;
        tl_sram_pkg::MaxU: raw = lt_u ? operand_i : old_i;
        tl_sram_pkg::Add:  raw = old_i + operand_i;
        // Out of range params are rejected by the checker
        default:           raw = old_i;
      endcase
    end else begin
      case (tl_sram_pkg::logic_param_e'(param_i))
        tl_sram_pkg::Xor:  raw = old_i ^ operand_i;
        tl_sram_pkg::Or:   raw = old_i | operand_i;
        tl_sram_pkg::And:  raw = old_i & operand_i;
        tl_sram_pkg::Swap: raw = operand_i;
        default:           raw = old_i;
      endcase
    end
  end

  // Unmasked bytes keep the old memory contents
  always_comb begin
    for (int i = 0; i < tl_sram_pkg::TlDbw; i++) begin
      result_o[8*i +: 8] = mask_i[i] ? raw[8*i +: 8] : old_i[8*i +: 8];
    end
  end

endmodule

/* hdl/tl_req_check.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// TL-UH A channel request checker
// Decodes one A beat into an internal request and flags every
// protocol violation, purely combinational
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module tl_req_check (
  input  tl_sram_pkg::tl_a_t tl_a_i,
  output tl_sram_pkg::req_t  req_o
);

  localparam int OffW = $clog2(tl_sram_pkg::TlDbw);

  logic [OffW-1:0]               offset;
  logic [tl_sram_pkg::TlDbw-1:0] lane_mask;
  logic                          size_err;
  logic                          align_err;
  logic                          mask_err;
  logic                          op_err;
  tl_sram_pkg::req_op_e          op;
  logic                          arith;

  // Byte offset inside the TL word
  assign offset = tl_a_i.address[OffW-1:0];

  // Bytes covered by size and address
  always_comb begin
    size_err  = 1'b0;
    align_err = 1'b0;
    case (tl_a_i.size)
      2'd0: begin
        lane_mask = tl_sram_pkg::TlDbw'(1) << offset;
      end
      2'd1: begin
        lane_mask = tl_sram_pkg::TlDbw'(3) << offset;
        align_err = offset[0];
      end
      2'd2: begin
        lane_mask = '1;
        align_err = (offset != '0);
      end
      default: begin
        // Larger than one word, bursts are not supported
        lane_mask = '1;
        size_err  = 1'b1;
      end
    endcase
  end

  // Opcode decode and per-opcode rules
  always_comb begin
    op       = tl_sram_pkg::OpWrite;
    arith    = 1'b0;
    op_err   = 1'b0;
    // No mask bits outside the addressed lanes
    mask_err = ((tl_a_i.mask & ~lane_mask) != '0);
    case (tl_a_i.opcode)
      tl_sram_pkg::Get: begin
        op       = tl_sram_pkg::OpRead;
        mask_err = (tl_a_i.mask != lane_mask);
      end
      tl_sram_pkg::PutFullData: begin
        mask_err = (tl_a_i.mask != lane_mask);
      end
      tl_sram_pkg::PutPartialData: begin
        op = tl_sram_pkg::OpWrite;
      end
      tl_sram_pkg::ArithmeticData: begin
        op     = tl_sram_pkg::OpAtomic;
        arith  = 1'b1;
        op_err = (tl_a_i.param > 3'(tl_sram_pkg::Add));
      end
      tl_sram_pkg::LogicalData: begin
        op     = tl_sram_pkg::OpAtomic;
        op_err = (tl_a_i.param > 3'(tl_sram_pkg::Swap));
      end
      default: begin
        // Intent and unknown opcodes answer with AccessAck and error
        op_err = 1'b1;
      end
    endcase
  end

  assign req_o = '{
    op:     op,
    arith:  arith,
    param:  tl_a_i.param,
    size:   tl_a_i.size,
    source: tl_a_i.source,
    addr:   tl_a_i.address[OffW +: tl_sram_pkg::SramAw],
    mask:   tl_a_i.mask,
    data:   tl_a_i.data,
    error:  size_err | align_err | mask_err | op_err
  };

endmodule

/* hdl/tl_sram_adapter.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// TileLink-UH to SRAM adapter top
// Checker, request FIFO, controller, atomic ALU and response FIFO
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module tl_sram_adapter (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  // TL-UH A channel
  input  tl_sram_pkg::tl_a_t     tl_a_i,
  output logic                   tl_a_ready_o,
  // TL-UH D channel
  output tl_sram_pkg::tl_d_t     tl_d_o,
  input  logic                   tl_d_ready_i,
  // SRAM port
  output tl_sram_pkg::sram_req_t sram_req_o,
  input  tl_sram_pkg::sram_rsp_t sram_rsp_i
);

  tl_sram_pkg::req_t            req_in;
  tl_sram_pkg::req_t            req_head;
  logic                         req_full;
  logic                         req_empty;
  logic                         req_pop;

  tl_sram_pkg::rsp_t            rsp_in;
  tl_sram_pkg::rsp_t            rsp_head;
  logic                         rsp_full;
  logic                         rsp_empty;
  logic                         rsp_push;

  logic [tl_sram_pkg::TlDw-1:0] alu_old;
  logic [tl_sram_pkg::TlDw-1:0] alu_result;

  tl_req_check i_req_check (
    .tl_a_i (tl_a_i),
    .req_o  (req_in)
  );

  // Accept while there is room for the decoded request
  assign tl_a_ready_o = !req_full;

  tl_sram_fifo #(
    .Depth (tl_sram_pkg::ReqDepth),
    .T     (tl_sram_pkg::req_t)
  ) i_req_fifo (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .push_i  (tl_a_i.valid && tl_a_ready_o),
    .data_i  (req_in),
    .full_o  (req_full),
    .pop_i   (req_pop),
    .data_o  (req_head),
    .empty_o (req_empty)
  );

  tl_sram_ctrl i_ctrl (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .req_i        (req_head),
    .req_valid_i  (!req_empty),
    .req_pop_o    (req_pop),
    .rsp_o        (rsp_in),
    .rsp_push_o   (rsp_push),
    .rsp_full_i   (rsp_full),
    .sram_req_o   (sram_req_o),
    .sram_rsp_i   (sram_rsp_i),
    .alu_old_o    (alu_old),
    .alu_result_i (alu_result)
  );

  // Operand, mask and param come from the request FIFO head
  tl_atomic_alu i_alu (
    .arith_i   (req_head.arith),
    .param_i   (req_head.param),
    .mask_i    (req_head.mask),
    .old_i     (alu_old),
    .operand_i (req_head.data),
    .result_o  (alu_result)
  );

  tl_sram_fifo #(
    .Depth (tl_sram_pkg::RspDepth),
    .T     (tl_sram_pkg::rsp_t)
  ) i_rsp_fifo (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .push_i  (rsp_push),
    .data_i  (rsp_in),
    .full_o  (rsp_full),
    .pop_i   (tl_d_ready_i && !rsp_empty),
    .data_o  (rsp_head),
    .empty_o (rsp_empty)
  );

  // D beat is the response FIFO head, stable until accepted
  assign tl_d_o = '{
    valid:  !rsp_empty,
    opcode: rsp_head.opcode,
    size:   rsp_head.size,
    source: rsp_head.source,
    data:   rsp_head.data,
    error:  rsp_head.error
  };

endmodule

/* hdl/tl_sram_ctrl.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// SRAM request controller
// Serves the head of the request FIFO on the SRAM port, one request
// at a time, and pushes its response into the response FIFO
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module tl_sram_ctrl (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  // Request FIFO head
  input  tl_sram_pkg::req_t            req_i,
  input  logic                         req_valid_i,
  output logic                         req_pop_o,
  // Response FIFO tail
  output tl_sram_pkg::rsp_t            rsp_o,
  output logic                         rsp_push_o,
  input  logic                         rsp_full_i,
  // SRAM port
  output tl_sram_pkg::sram_req_t       sram_req_o,
  input  tl_sram_pkg::sram_rsp_t       sram_rsp_i,
  // Atomic ALU
  output logic [tl_sram_pkg::TlDw-1:0] alu_old_o,
  input  logic [tl_sram_pkg::TlDw-1:0] alu_result_i
);

  typedef enum logic [2:0] {
    Idle,
    Read,        // SRAM request held until grant, read or plain write
    WaitData,
    AtomicWrite,
    Respond
  } ctrl_state_e;

  ctrl_state_e                  state_q;
  logic [tl_sram_pkg::TlDw-1:0] rd_data_q;
  logic                         rd_err_q;
  logic [tl_sram_pkg::TlDw-1:0] bit_mask;
  logic                         is_write;
  logic                         start;
  logic                         we;

  assign is_write = (req_i.op == tl_sram_pkg::OpWrite);

  // Reads and atomics only start with a free response slot,
  // so returning read data never has to wait
  assign start = req_valid_i && !req_i.error && (is_write || !rsp_full_i);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= Idle;
    end else begin
      case (state_q)
        Idle: begin
          if (req_valid_i && req_i.error) begin
            // Rejected request, SRAM is never touched
            state_q <= Respond;
          end else if (start) begin
            state_q <= Read;
          end
        end
        Read: begin
          if (sram_rsp_i.gnt) begin
            state_q <= is_write ? Respond : WaitData;
          end
        end
        WaitData: begin
          if (sram_rsp_i.rvalid) begin
            // Failed atomic read skips the write back
            if (req_i.op == tl_sram_pkg::OpAtomic && !sram_rsp_i.rerror) begin
              state_q <= AtomicWrite;
            end else begin
              state_q <= Respond;
            end
          end
        end
        AtomicWrite: begin
          if (sram_rsp_i.gnt) begin
            state_q <= Respond;
          end
        end
        Respond: begin
          if (!rsp_full_i) begin
            state_q <= Idle;
          end
        end
        default: state_q <= Idle;
      endcase
    end
  end

  // Read data and error, old word for atomics
  always_ff @(posedge clk_i) begin
    if (state_q == WaitData && sram_rsp_i.rvalid) begin
      rd_data_q <= sram_rsp_i.rdata;
      rd_err_q  <= sram_rsp_i.rerror;
    end
  end

  assign alu_old_o = rd_data_q;

  // Byte enables to bit enables
  always_comb begin
    for (int i = 0; i < tl_sram_pkg::TlDbw; i++) begin
      bit_mask[8*i +: 8] = {8{req_i.mask[i]}};
    end
  end

  // Request FIFO head stays put until popped, so the SRAM fields
  // come straight from it and are stable while req is held
  assign we = (state_q == AtomicWrite) || is_write;

  assign sram_req_o = '{
    req:   (state_q == Read) || (state_q == AtomicWrite),
    we:    we,
    addr:  req_i.addr,
    wdata: (state_q == AtomicWrite) ? alu_result_i : req_i.data,
    wmask: we ? bit_mask : '0
  };

  // Pop and push together, one response per request
  assign rsp_push_o = (state_q == Respond) && !rsp_full_i;
  assign req_pop_o  = rsp_push_o;

  // Atomics return the old word, writes carry no data
  assign rsp_o = '{
    opcode: is_write ? tl_sram_pkg::AccessAck : tl_sram_pkg::AccessAckData,
    size:   req_i.size,
    source: req_i.source,
    data:   (is_write || req_i.error) ? '0 : rd_data_q,
    error:  req_i.error | (!is_write & rd_err_q)
  };

  // Held SRAM request does not change before it is granted
  a_sram_req_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    sram_req_o.req && !sram_rsp_i.gnt |=> sram_req_o.req && $stable(sram_req_o));

endmodule

/* hdl/tl_sram_fifo.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Synchronous FIFO
// Circular buffer of Depth entries of any packed type with a registered
// output and no pass-through from push to pop
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module tl_sram_fifo #(
  parameter int unsigned Depth = 2,
  parameter type         T     = logic
) (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic push_i,
  input  T     data_i,
  output logic full_o,
  input  logic pop_i,
  output T     data_o,
  output logic empty_o
);

  // Pointer is at least one bit wide even for a single entry
  localparam int PtrW = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int CntW = $clog2(Depth + 1);

  T              mem_q [Depth];
  logic [PtrW-1:0] wr_ptr_q;
  logic [PtrW-1:0] rd_ptr_q;
  logic [CntW-1:0] cnt_q;

  assign full_o  = (cnt_q == CntW'(Depth));
  assign empty_o = (cnt_q == '0);
  // Head entry is only meaningful while not empty
  assign data_o  = mem_q[rd_ptr_q];

  // Payload storage
  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  // Pointers wrap at Depth even when it is not a power of two
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= (wr_ptr_q == PtrW'(Depth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop_i) begin
        rd_ptr_q <= (rd_ptr_q == PtrW'(Depth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      // Simultaneous push and pop leaves the count alone
      if (push_i && !pop_i) begin
        cnt_q <= cnt_q + 1'b1;
      end else if (pop_i && !push_i) begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

  // Producer must respect full
  a_no_push_full: assert property (@(posedge clk_i) disable iff (!rst_ni)
    push_i |-> !full_o);

  // Consumer must respect empty
  a_no_pop_empty: assert property (@(posedge clk_i) disable iff (!rst_ni)
    pop_i |-> !empty_o);

endmodule

/* hdl/tl_sram_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// TileLink-UH to SRAM adapter package
// Widths, FIFO depths, opcode enums and the channel structs shared
// by the adapter blocks and the testbench
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package tl_sram_pkg;

  // TL-UH bus geometry
  localparam int TlDw   = 32;
  localparam int TlDbw  = 4;
  localparam int TlAw   = 32;
  localparam int TlAiw  = 8;
  localparam int TlSzw  = 2;

  // SRAM word address width
  localparam int SramAw = 10;

  // Outstanding request and response storage
  localparam int ReqDepth = 2;
  localparam int RspDepth = 2;

  // A channel opcodes, TileLink encoding
  typedef enum logic [2:0] {
    PutFullData    = 3'h0,
    PutPartialData = 3'h1,
    ArithmeticData = 3'h2,
    LogicalData    = 3'h3,
    Get            = 3'h4,
    Intent         = 3'h5
  } tl_a_op_e;

  // D channel opcodes
  typedef enum logic [2:0] {
    AccessAck     = 3'h0,
    AccessAckData = 3'h1
  } tl_d_op_e;

  // Param field of ArithmeticData
  typedef enum logic [2:0] {
    Min  = 3'h0,
    Max  = 3'h1,
    MinU = 3'h2,
    MaxU = 3'h3,
    Add  = 3'h4
  } arith_param_e;

  // Param field of LogicalData
  typedef enum logic [2:0] {
    Xor  = 3'h0,
    Or   = 3'h1,
    And  = 3'h2,
    Swap = 3'h3
  } logic_param_e;

  // Internal operation class
  typedef enum logic [1:0] {
    OpRead   = 2'h0,
    OpWrite  = 2'h1,
    OpAtomic = 2'h2
  } req_op_e;

  // Single A beat from the host
  typedef struct packed {
    logic              valid;
    tl_a_op_e          opcode;
    logic [2:0]        param;
    logic [TlSzw-1:0]  size;
    logic [TlAiw-1:0]  source;
    logic [TlAw-1:0]   address;
    logic [TlDbw-1:0]  mask;
    logic [TlDw-1:0]   data;
  } tl_a_t;

  // Single D beat back to the host
  typedef struct packed {
    logic              valid;
    tl_d_op_e          opcode;
    logic [TlSzw-1:0]  size;
    logic [TlAiw-1:0]  source;
    logic [TlDw-1:0]   data;
    logic              error;
  } tl_d_t;

  // Decoded request as held in the request FIFO
  typedef struct packed {
    req_op_e           op;
    logic              arith;
    logic [2:0]        param;
    logic [TlSzw-1:0]  size;
    logic [TlAiw-1:0]  source;
    logic [SramAw-1:0] addr;
    logic [TlDbw-1:0]  mask;
    logic [TlDw-1:0]   data;
    logic              error;
  } req_t;

  // Response entry as held in the response FIFO
  typedef struct packed {
    tl_d_op_e          opcode;
    logic [TlSzw-1:0]  size;
    logic [TlAiw-1:0]  source;
    logic [TlDw-1:0]   data;
    logic              error;
  } rsp_t;

  // SRAM request port, wmask is per bit
  typedef struct packed {
    logic              req;
    logic              we;
    logic [SramAw-1:0] addr;
    logic [TlDw-1:0]   wdata;
    logic [TlDw-1:0]   wmask;
  } sram_req_t;

  // SRAM response port
  typedef struct packed {
    logic              gnt;
    logic              rvalid;
    logic [TlDw-1:0]   rdata;
    logic              rerror;
  } sram_rsp_t;

endpackage

/* verification/sram_model.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Behavioral SRAM for the adapter testbench
// Request/grant port with grant stalls, a read latency chosen per
// read and an injectable uncorrectable read error
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module sram_model (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  tl_sram_pkg::sram_req_t sram_req_i,
  output tl_sram_pkg::sram_rsp_t sram_rsp_o,
  // Stall and latency choices from the testbench
  input  logic                   stall_i,
  input  logic [1:0]             lat_i,
  input  logic                   err_i
);

  localparam int Words = 2 ** tl_sram_pkg::SramAw;

  logic [tl_sram_pkg::TlDw-1:0] mem [Words];
  logic                         gnt;
  logic                         rvalid;
  logic                         pend_q;
  logic [1:0]                   lat_q;
  logic [tl_sram_pkg::TlDw-1:0] rdata_q;
  logic                         rerr_q;

  // Start-up contents with its own word at every address
  function automatic logic [31:0] fill_word(logic [31:0] a);
    return (a * 32'h0100_0193) ^ 32'h5A5A_A5A5;
  endfunction

  initial begin
    for (int a = 0; a < Words; a++) begin
      mem[a] = fill_word(32'(a));
    end
  end

  assign gnt = sram_req_i.req && !stall_i;

  // Bit-masked write at grant
  always @(posedge clk_i) begin
    if (gnt && sram_req_i.we) begin
      mem[sram_req_i.addr] <= (mem[sram_req_i.addr] & ~sram_req_i.wmask) |
                              (sram_req_i.wdata & sram_req_i.wmask);
    end
  end

  // One read in flight with its data captured at grant and held for lat_i cycles
  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pend_q <= 1'b0;
      lat_q  <= '0;
    end else if (gnt && !sram_req_i.we) begin
      pend_q <= 1'b1;
      lat_q  <= lat_i;
    end else if (pend_q) begin
      if (lat_q == '0) begin
        pend_q <= 1'b0;
      end else begin
        lat_q <= lat_q - 2'd1;
      end
    end
  end

  always @(posedge clk_i) begin
    if (gnt && !sram_req_i.we) begin
      rdata_q <= mem[sram_req_i.addr];
      rerr_q  <= err_i;
    end
  end

  assign rvalid = pend_q && (lat_q == '0);

  assign sram_rsp_o = '{
    gnt:    gnt,
    rvalid: rvalid,
    rdata:  rvalid ? rdata_q : '0,
    rerror: rvalid && rerr_q
  };

endmodule

/* verification/tb_tl_sram_adapter.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the TileLink-UH to SRAM adapter
// Directed tests for puts, gets, atomics, request errors and D
// channel back-pressure, checked against a reference memory
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module tb_tl_sram_adapter;

  localparam int TimeoutCycles = 500;
  localparam int Words         = 2 ** tl_sram_pkg::SramAw;
  // Requests that fit in the adapter while D is held off
  localparam int Capacity      = tl_sram_pkg::ReqDepth + tl_sram_pkg::RspDepth;

  logic                   clk = 1'b0;
  logic                   rst_n;
  tl_sram_pkg::tl_a_t     tl_a;
  logic                   tl_a_ready;
  tl_sram_pkg::tl_d_t     tl_d;
  logic                   tl_d_ready;
  tl_sram_pkg::sram_req_t sram_req;
  tl_sram_pkg::sram_rsp_t sram_rsp;
  logic                   gnt_stall = 1'b0;
  logic [1:0]             rd_lat = 2'd0;
  logic                   err_inject;

  // Separate LFSR states for stimulus and for SRAM stalls
  logic [15:0]            stim_lfsr;
  logic [15:0]            stall_lfsr = 16'd34;
  logic [31:0]            ref_mem [Words];
  logic [7:0]             src_cnt;

  always #5 clk = ~clk;

  tl_sram_adapter i_dut (
    .clk_i        (clk),
    .rst_ni       (rst_n),
    .tl_a_i       (tl_a),
    .tl_a_ready_o (tl_a_ready),
    .tl_d_o       (tl_d),
    .tl_d_ready_i (tl_d_ready),
    .sram_req_o   (sram_req),
    .sram_rsp_i   (sram_rsp)
  );

  sram_model i_sram (
    .clk_i      (clk),
    .rst_ni     (rst_n),
    .sram_req_i (sram_req),
    .sram_rsp_o (sram_rsp),
    .stall_i    (gnt_stall),
    .lat_i      (rd_lat),
    .err_i      (err_inject)
  );

  // Galois LFSR, x^16 + x^14 + x^13 + x^11 + 1, one step per bit
  function automatic logic lfsr_bit(inout logic [15:0] state);
    logic out;
    out   = state[0];
    state = state >> 1;
    if (out) begin
      state = state ^ 16'hB400;
    end
    return out;
  endfunction

  function automatic logic [31:0] rand_bits(int unsigned n);
    logic [31:0] val;
    val = '0;
    for (int unsigned i = 0; i < n; i++) begin
      val = {val[30:0], lfsr_bit(stim_lfsr)};
    end
    return val;
  endfunction

  // Random grant stalls and read latency, new choice every cycle
  always @(negedge clk) begin
    gnt_stall = lfsr_bit(stall_lfsr);
    rd_lat[0] = lfsr_bit(stall_lfsr);
    rd_lat[1] = lfsr_bit(stall_lfsr);
  end

  // Same start-up contents as the SRAM model
  function automatic logic [31:0] fill_word(logic [31:0] a);
    return (a * 32'h0100_0193) ^ 32'h5A5A_A5A5;
  endfunction

  function automatic logic [31:0] word_addr(logic [9:0] w);
    return 32'(w) << 2;
  endfunction

  function automatic logic [31:0] merge_bytes(logic [31:0] old, logic [31:0] upd,
                                              logic [3:0] mask);
    logic [31:0] res;
    res = old;
    for (int i = 0; i < 4; i++) begin
      if (mask[i]) begin
        res[8*i +: 8] = upd[8*i +: 8];
      end
    end
    return res;
  endfunction

  // New memory word of an atomic, from the TL-UH param definitions
  function automatic logic [31:0] atomic_expect(logic arith, logic [2:0] param,
                                                logic [3:0] mask, logic [31:0] old,
                                                logic [31:0] opnd);
    logic [31:0] raw;
    raw = old;
    if (arith) begin
      case (param)
        3'd0: raw = ($signed(opnd) < $signed(old)) ? opnd : old;
        3'd1: raw = ($signed(opnd) > $signed(old)) ? opnd : old;
        3'd2: raw = (opnd < old) ? opnd : old;
        3'd3: raw = (opnd > old) ? opnd : old;
        3'd4: raw = old + opnd;
        default: raw = old;
      endcase
    end else begin
      case (param)
        3'd0: raw = old ^ opnd;
        3'd1: raw = old | opnd;
        3'd2: raw = old & opnd;
        3'd3: raw = opnd;
        default: raw = old;
      endcase
    end
    return merge_bytes(old, raw, mask);
  endfunction

  task automatic fail_value(string test, string what, logic [31:0] exp, logic [31:0] act);
    $display("CHECK FAILED: %s %s expected %h actual %h", test, what, exp, act);
    $display("TEST RESULT: FAIL");
    $fatal(1, "Simulation stopped at the first mismatch");
  endtask

  task automatic fail_plain(string msg);
    $display("ERROR: %s", msg);
    $display("TEST RESULT: FAIL");
    $fatal(1, "Simulation stopped");
  endtask

  task automatic check_value(string test, string what, logic [31:0] exp, logic [31:0] act);
    assert (act === exp) else fail_value(test, what, exp, act);
  endtask

  // A beat with a fresh source id
  function automatic tl_sram_pkg::tl_a_t make_beat(tl_sram_pkg::tl_a_op_e op,
      logic [2:0] param, logic [1:0] size, logic [31:0] addr, logic [3:0] mask,
      logic [31:0] data);
    tl_sram_pkg::tl_a_t beat;
    beat = '{valid: 1'b1, opcode: op, param: param, size: size, source: src_cnt,
             address: addr, mask: mask, data: data};
    src_cnt = src_cnt + 8'd1;
    return beat;
  endfunction

  // Called on a falling edge, returns on the falling edge after the accept
  task automatic send_beat(string test, tl_sram_pkg::tl_a_t beat);
    int cnt;
    cnt  = 0;
    tl_a = beat;
    while (!tl_a_ready) begin
      @(negedge clk);
      cnt++;
      if (cnt > TimeoutCycles) begin
        fail_plain({test, ": A channel was never ready"});
      end
    end
    @(negedge clk);
    tl_a.valid = 1'b0;
  endtask

  task automatic recv_beat(string test, output tl_sram_pkg::tl_d_t d);
    int cnt;
    cnt        = 0;
    tl_d_ready = 1'b1;
    while (!tl_d.valid) begin
      @(negedge clk);
      cnt++;
      if (cnt > TimeoutCycles) begin
        fail_plain({test, ": no D channel response arrived"});
      end
    end
    d = tl_d;
    @(negedge clk);
    tl_d_ready = 1'b0;
  endtask

  task automatic check_rsp(string test, tl_sram_pkg::tl_a_t beat, tl_sram_pkg::tl_d_t d,
                           tl_sram_pkg::tl_d_op_e exp_op, logic exp_err,
                           logic [31:0] exp_data);
    check_value(test, "opcode", 32'(exp_op), 32'(d.opcode));
    check_value(test, "source", 32'(beat.source), 32'(d.source));
    check_value(test, "size", 32'(beat.size), 32'(d.size));
    check_value(test, "error", 32'(exp_err), 32'(d.error));
    if (exp_op == tl_sram_pkg::AccessAckData && !exp_err) begin
      check_value(test, "data", exp_data, d.data);
    end
  endtask

  // One request and its response
  task automatic access(string test, tl_sram_pkg::tl_a_op_e op, logic [2:0] param,
                        logic [1:0] size, logic [31:0] addr, logic [3:0] mask,
                        logic [31:0] data, tl_sram_pkg::tl_d_op_e exp_op,
                        logic exp_err, logic [31:0] exp_data);
    tl_sram_pkg::tl_a_t beat;
    tl_sram_pkg::tl_d_t d;
    beat = make_beat(op, param, size, addr, mask, data);
    send_beat(test, beat);
    recv_beat(test, d);
    check_rsp(test, beat, d, exp_op, exp_err, exp_data);
  endtask

  task automatic read_check(string test, logic [9:0] w);
    access(test, tl_sram_pkg::Get, 3'd0, 2'd2, word_addr(w), 4'hf, 32'd0,
           tl_sram_pkg::AccessAckData, 1'b0, ref_mem[w]);
  endtask

  task automatic test_basic();
    logic [9:0]  w;
    logic [31:0] d;
    check_value("basic", "d_valid after reset", 32'd0, 32'(tl_d.valid));
    check_value("basic", "sram req after reset", 32'd0, 32'(sram_req.req));
    check_value("basic", "a_ready after reset", 32'd1, 32'(tl_a_ready));
    w = 10'(rand_bits(10));
    d = rand_bits(32);
    access("basic", tl_sram_pkg::PutFullData, 3'd0, 2'd2, word_addr(w), 4'hf, d,
           tl_sram_pkg::AccessAck, 1'b0, 32'd0);
    ref_mem[w] = d;
    read_check("basic", w);
  endtask

  // Full-word puts with random masks, then single bytes
  task automatic test_partial();
    logic [9:0]  w;
    logic [3:0]  m;
    logic [1:0]  off;
    logic [31:0] d;
    for (int i = 0; i < 8; i++) begin
      w = 10'(rand_bits(10));
      d = rand_bits(32);
      if (i < 4) begin
        m = 4'(rand_bits(4));
        access("partial", tl_sram_pkg::PutPartialData, 3'd0, 2'd2, word_addr(w), m, d,
               tl_sram_pkg::AccessAck, 1'b0, 32'd0);
      end else begin
        off = 2'(rand_bits(2));
        m   = 4'd1 << off;
        access("partial", tl_sram_pkg::PutPartialData, 3'd0, 2'd0,
               word_addr(w) + 32'(off), m, d, tl_sram_pkg::AccessAck, 1'b0, 32'd0);
      end
      ref_mem[w] = merge_bytes(ref_mem[w], d, m);
      read_check("partial", w);
    end
  endtask

  // Every param twice, old word back, new word read afterwards
  task automatic test_atomics();
    logic [9:0]  w;
    logic [3:0]  m;
    logic [31:0] opnd;
    logic        arith;
    tl_sram_pkg::tl_a_op_e op;
    for (int r = 0; r < 2; r++) begin
      for (int k = 0; k < 9; k++) begin
        arith = (k < 5);
        op    = arith ? tl_sram_pkg::ArithmeticData : tl_sram_pkg::LogicalData;
        w     = 10'(rand_bits(10));
        m     = 4'(rand_bits(4));
        opnd  = rand_bits(32);
        access("atomic", op, 3'(arith ? k : k - 5), 2'd2, word_addr(w), m, opnd,
               tl_sram_pkg::AccessAckData, 1'b0, ref_mem[w]);
        ref_mem[w] = atomic_expect(arith, 3'(arith ? k : k - 5), m, ref_mem[w], opnd);
        read_check("atomic", w);
      end
    end
  endtask

  task automatic test_errors();
    logic [9:0]  w;
    logic [31:0] a;
    w = 10'(rand_bits(10));
    a = word_addr(w);
    access("errors", tl_sram_pkg::Intent, 3'd0, 2'd2, a, 4'hf, rand_bits(32),
           tl_sram_pkg::AccessAck, 1'b1, 32'd0);
    access("errors", tl_sram_pkg::Get, 3'd0, 2'd3, a & ~32'h7, 4'hf, 32'd0,
           tl_sram_pkg::AccessAckData, 1'b1, 32'd0);
    access("errors", tl_sram_pkg::PutFullData, 3'd0, 2'd2, a + 32'd2, 4'hf, rand_bits(32),
           tl_sram_pkg::AccessAck, 1'b1, 32'd0);
    access("errors", tl_sram_pkg::Get, 3'd0, 2'd2, a, 4'h3, 32'd0,
           tl_sram_pkg::AccessAckData, 1'b1, 32'd0);
    // Byte put whose mask lane does not match the address
    access("errors", tl_sram_pkg::PutPartialData, 3'd0, 2'd0, a + 32'd1, 4'h4,
           rand_bits(32), tl_sram_pkg::AccessAck, 1'b1, 32'd0);
    access("errors", tl_sram_pkg::LogicalData, 3'd5, 2'd2, a, 4'hf, rand_bits(32),
           tl_sram_pkg::AccessAckData, 1'b1, 32'd0);
    read_check("errors", w);
    // Uncorrectable read error, atomic must not write back
    err_inject = 1'b1;
    access("errors", tl_sram_pkg::Get, 3'd0, 2'd2, a, 4'hf, 32'd0,
           tl_sram_pkg::AccessAckData, 1'b1, 32'd0);
    access("errors", tl_sram_pkg::LogicalData, 3'd3, 2'd2, a, 4'hf, ~ref_mem[w],
           tl_sram_pkg::AccessAckData, 1'b1, 32'd0);
    err_inject = 1'b0;
    read_check("errors", w);
  endtask

  task automatic test_backpressure();
    logic [9:0]         words [$];
    tl_sram_pkg::tl_a_t beats [$];
    tl_sram_pkg::tl_a_t beat;
    tl_sram_pkg::tl_d_t d;
    logic [9:0]         w;
    tl_d_ready = 1'b0;
    for (int i = 0; i < Capacity; i++) begin
      w    = 10'(rand_bits(10));
      beat = make_beat(tl_sram_pkg::Get, 3'd0, 2'd2, word_addr(w), 4'hf, 32'd0);
      words.push_back(w);
      beats.push_back(beat);
      send_beat("backpressure", beat);
    end
    // Both FIFOs full, nothing moves while D is held off
    repeat (8) begin
      check_value("backpressure", "a_ready while D stalled", 32'd0, 32'(tl_a_ready));
      check_value("backpressure", "d_valid while D stalled", 32'd1, 32'(tl_d.valid));
      @(negedge clk);
    end
    while (words.size() > 0) begin
      w    = words.pop_front();
      beat = beats.pop_front();
      recv_beat("backpressure", d);
      check_rsp("backpressure", beat, d, tl_sram_pkg::AccessAckData, 1'b0, ref_mem[w]);
    end
  endtask

  initial begin
    tl_a       = '0;
    tl_d_ready = 1'b0;
    err_inject = 1'b0;
    rst_n      = 1'b0;
    stim_lfsr  = 16'd34;
    src_cnt    = 8'd0;
    for (int a = 0; a < Words; a++) begin
      ref_mem[a] = fill_word(32'(a));
    end
    repeat (4) @(negedge clk);
    rst_n = 1'b1;
    test_basic();
    test_partial();
    test_atomics();
    test_errors();
    repeat (3) test_backpressure();
    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule
